//--- Makefile
SIM := obj_dir/Vtb_execute_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f execute_stage.f --top-module tb_execute_stage

run: compile
	$(SIM) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- design/alu.sv
// Integer ALU
`timescale 1ns/100ps
`default_nettype none

module alu import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire alu_op_e          op_i,
    input  wire [XLEN-1:0]        a_i,
    input  wire [XLEN-1:0]        b_i,
    output logic [XLEN-1:0]       result_o,
    output logic [XLEN-1:0]       sum_o     // Branch target and memory address
);

    localparam int SW = $clog2(XLEN);

    logic [SW-1:0] shamt;

    assign sum_o = a_i + b_i;
    assign shamt = b_i[SW-1:0];   // Only the low bits select the shift

    always_comb begin
        case (op_i)
            ADD:     result_o = sum_o;
            SUB:     result_o = a_i - b_i;
            AND:     result_o = a_i & b_i;
            OR:      result_o = a_i | b_i;
            XOR:     result_o = a_i ^ b_i;
            SLL:     result_o = a_i << shamt;
            SRL:     result_o = a_i >> shamt;
            SRA:     result_o = $signed(a_i) >>> shamt;   // Sign fill
            SLT:     result_o = XLEN'($signed(a_i) < $signed(b_i));
            SLTU:    result_o = XLEN'(a_i < b_i);
            default: result_o = sum_o;
        endcase
    end

endmodule

`default_nettype wire

//--- design/divider.sv
// Radix-2 restoring divider
`timescale 1ns/100ps
`default_nettype none

module divider import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire                   clk_i,
    input  wire                   rst_i,
    input  wire                   start_i,
    input  wire div_op_e          op_i,
    input  wire [XLEN-1:0]        dividend_i,
    input  wire [XLEN-1:0]        divisor_i,
    output logic [XLEN-1:0]       result_o,
    output logic                  done_o
);

    localparam int CW = $clog2(XLEN);

    typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

    state_e          state_q;
    logic [CW-1:0]   cnt_q;
    logic [XLEN-1:0] quo_q;       // Dividend magnitude shifts out, quotient shifts in
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dvs_q;
    logic [XLEN-1:0] dividend_q;
    div_op_e         op_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    logic            zero_q;
    logic            is_signed;
    logic            a_neg;
    logic            b_neg;
    logic            is_rem;
    logic [XLEN:0]   partial;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;

    assign is_signed = (op_i == DIV) || (op_i == REM);
    assign a_neg     = is_signed & dividend_i[XLEN-1];
    assign b_neg     = is_signed & divisor_i[XLEN-1];

    // One trial subtraction per cycle
    assign partial = {rem_q, quo_q[XLEN-1]};
    assign diff    = partial - {1'b0, dvs_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        cnt_q   <= '0;
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CW'(XLEN - 1)) state_q <= DONE;
                end
                DONE:    if (!start_i) state_q <= IDLE;   // Hold result until start drops
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            quo_q      <= a_neg ? -dividend_i : dividend_i;
            rem_q      <= '0;
            dvs_q      <= b_neg ? -divisor_i : divisor_i;
            dividend_q <= dividend_i;
            op_q       <= op_i;
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;        // Remainder takes the dividend sign
            zero_q     <= (divisor_i == '0);
        end else if (state_q == RUN) begin
            quo_q <= {quo_q[XLEN-2:0], ~diff[XLEN]};
            rem_q <= diff[XLEN] ? partial[XLEN-1:0] : diff[XLEN-1:0];
        end
    end

    // Sign fix-up, overflow case falls out of the magnitudes
    assign is_rem  = (op_q == REM) || (op_q == REMU);
    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    assign result_o = zero_q ? (is_rem ? dividend_q : '1) : (is_rem ? rem_fix : quo_fix);
    assign done_o   = (state_q == DONE) || (state_q == IDLE && !start_i);

endmodule

`default_nettype wire

//--- design/exec_pkg.sv
// Execute stage operation encodings
`default_nettype none

package exec_pkg;

    // Unit that executes the current micro-operation
    typedef enum logic [2:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_DIV,
        UNIT_MEM,
        UNIT_BRANCH
    } unit_e;

    typedef enum logic [3:0] {
        ADD, SUB,
        AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU
    } alu_op_e;

    typedef enum logic [1:0] {DIV, DIVU, REM, REMU} div_op_e;

    // Conditional branches use the decode compare flags
    typedef enum logic [3:0] {
        BR_NONE,
        BEQ, BNE,
        BLT, BGE,
        BLTU, BGEU,
        JAL, JALR
    } branch_op_e;

    // Source written to rd at write-back
    typedef enum logic [1:0] {WB_NONE, WB_RESULT, WB_PC_NEXT} wb_sel_e;

endpackage

`default_nettype wire

//--- design/execute_stage.sv
// Execute stage top
`timescale 1ns/100ps
`default_nettype none

module execute_stage import exec_pkg::*, mem_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire                 stall_i,
    output logic                ready_o,

    // Decode side
    input  wire unit_e          unit_i,
    input  wire alu_op_e        alu_op_i,
    input  wire div_op_e        div_op_i,
    input  wire branch_op_e     branch_op_i,
    input  wire wb_sel_e        wb_sel_i,
    input  wire mem_op_e        mem_op_i,
    input  wire mem_size_e      mem_size_i,
    input  wire                 mem_signed_i,
    input  wire [XLEN-1:0]      op_a_i,
    input  wire [XLEN-1:0]      op_b_i,
    input  wire [31:0]          store_data_i,
    input  wire [4:0]           rd_addr_i,
    input  wire [31:1]          pc_next_i,
    input  wire [2:0]           cmp_flags_i,      // {lt, ltu, eq}

    // Branch resolution
    output logic                branch_taken_o,
    output logic [31:1]         branch_target_o,

    // Write-back register
    output logic [4:0]          wb_rd_addr_o,
    output logic [XLEN-1:0]     wb_rd_data_o,
    output logic [31:1]         wb_pc_next_o,
    output wb_sel_e             wb_sel_o,
    output logic [XLEN-1:0]     fwd_data_o,

    // Memory handshake
    output logic                mem_req_o,
    output logic [31:0]         mem_addr_o,
    output logic [31:0]         mem_wdata_o,
    output logic [3:0]          mem_mask_o,
    output logic                mem_we_o,
    input  wire                 mem_ack_i,
    input  wire [31:0]          mem_rdata_i
);

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] alu_sum;
    logic [XLEN-1:0] div_result;
    logic [31:0]     mem_load_data;
    logic            div_done;
    logic            mem_done;
    logic [XLEN-1:0] next_result;
    logic            wb_load;

    alu #(.XLEN(XLEN)) alu_i (
        .op_i     (alu_op_i),
        .a_i      (op_a_i),
        .b_i      (op_b_i),
        .result_o (alu_result),
        .sum_o    (alu_sum)
    );

    divider #(.XLEN(XLEN)) divider_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (unit_i == UNIT_DIV),   // Level start while selected
        .op_i       (div_op_i),
        .dividend_i (op_a_i),
        .divisor_i  (op_b_i),
        .result_o   (div_result),
        .done_o     (div_done)
    );

    mem_access_unit mem_access_unit_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (unit_i == UNIT_MEM),
        .op_i         (mem_op_i),
        .size_i       (mem_size_i),
        .signed_i     (mem_signed_i),
        .addr_i       (alu_sum[31:0]),      // Effective address a + b
        .store_data_i (store_data_i),
        .load_data_o  (mem_load_data),
        .done_o       (mem_done),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_mask_o   (mem_mask_o),
        .mem_we_o     (mem_we_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    assign ready_o = div_done & mem_done;

    always_comb begin
        case (branch_op_i)
            BEQ:     branch_taken_o = cmp_flags_i[0];
            BNE:     branch_taken_o = ~cmp_flags_i[0];
            BLT:     branch_taken_o = cmp_flags_i[2];
            BGE:     branch_taken_o = ~cmp_flags_i[2];
            BLTU:    branch_taken_o = cmp_flags_i[1];
            BGEU:    branch_taken_o = ~cmp_flags_i[1];
            JAL,
            JALR:    branch_taken_o = 1'b1;
            default: branch_taken_o = 1'b0;   // Never taken by accident
        endcase
    end

    assign branch_target_o = alu_sum[31:1];

    always_comb begin
        case (unit_i)
            UNIT_ALU,
            UNIT_BRANCH: next_result = alu_result;
            UNIT_DIV:    next_result = div_result;
            UNIT_MEM:    next_result = XLEN'(mem_load_data);
            default:     next_result = '0;
        endcase
    end

    assign fwd_data_o = next_result;

    // Loads unless the next stage stalls a finished operation
    assign wb_load = !stall_i || !ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_sel_o <= WB_NONE;
        end else if (wb_load) begin
            wb_sel_o <= (unit_i == UNIT_NONE) ? WB_NONE : wb_sel_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_load) begin
            wb_rd_addr_o <= rd_addr_i;
            wb_rd_data_o <= next_result;
            wb_pc_next_o <= pc_next_i;
        end
    end

endmodule

`default_nettype wire

//--- design/mem_access_unit.sv
// Load/store sequencer
`timescale 1ns/100ps
`default_nettype none

module mem_access_unit import mem_pkg::*; (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              start_i,
    input  wire mem_op_e     op_i,
    input  wire mem_size_e   size_i,
    input  wire              signed_i,
    input  wire [31:0]       addr_i,
    input  wire [31:0]       store_data_i,
    output logic [31:0]      load_data_o,
    output logic             done_o,

    // Four-phase memory port
    output logic             mem_req_o,
    output logic [31:0]      mem_addr_o,
    output logic [31:0]      mem_wdata_o,
    output logic [3:0]       mem_mask_o,
    output logic             mem_we_o,
    input  wire              mem_ack_i,
    input  wire [31:0]       mem_rdata_i
);

    typedef enum logic [1:0] {IDLE, REQ, RELEASE, DONE} state_e;

    state_e      state_q;
    mem_size_e   size_q;
    logic        signed_q;
    logic [1:0]  lo_q;          // Byte offset within the word
    logic [31:0] aligned;
    logic [31:0] load_ext;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (start_i) state_q <= REQ;
                REQ:     if (mem_ack_i) state_q <= RELEASE;
                RELEASE: if (!mem_ack_i) state_q <= DONE;   // Wait for ack to fall
                DONE:    if (!start_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request fields latched once and held through the handshake
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            mem_addr_o  <= {addr_i[31:2], 2'b00};
            mem_wdata_o <= rol_bytes(store_data_i, addr_i[1:0]);
            mem_mask_o  <= lane_mask(size_i, addr_i[1:0]);
            mem_we_o    <= (op_i == MEM_STORE);
            size_q      <= size_i;
            signed_q    <= signed_i;
            lo_q        <= addr_i[1:0];
        end
        if (state_q == REQ && mem_ack_i && !mem_we_o) begin
            load_data_o <= load_ext;
        end
    end

    // Move the addressed lane down to bit 0
    assign aligned = rol_bytes(mem_rdata_i, 2'd0 - lo_q);

    always_comb begin
        case (size_q)
            SIZE_B:  load_ext = {{24{signed_q & aligned[7]}}, aligned[7:0]};
            SIZE_H:  load_ext = {{16{signed_q & aligned[15]}}, aligned[15:0]};
            default: load_ext = aligned;
        endcase
    end

    assign mem_req_o = (state_q == REQ);
    assign done_o    = (state_q == DONE) || (state_q == IDLE && !start_i);

endmodule

`default_nettype wire

//--- design/mem_pkg.sv
// Memory path definitions
`default_nettype none

package mem_pkg;

    typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W} mem_size_e;
    typedef enum logic {MEM_LOAD, MEM_STORE} mem_op_e;

    // Byte enables for an access of the given size
    function automatic logic [3:0] lane_mask(mem_size_e size, logic [1:0] lo);
        case (size)
            SIZE_B:  return 4'b0001 << lo;
            SIZE_H:  return 4'b0011 << lo;
            default: return 4'b1111;
        endcase
    endfunction

    // Rotate a word left by whole bytes
    function automatic logic [31:0] rol_bytes(logic [31:0] w, logic [1:0] n);
        case (n)
            2'd1:    return {w[23:0], w[31:24]};
            2'd2:    return {w[15:0], w[31:16]};
            2'd3:    return {w[7:0], w[31:8]};
            default: return w;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- execute_stage.f
design/exec_pkg.sv
design/mem_pkg.sv
design/alu.sv
design/divider.sv
design/mem_access_unit.sv
design/execute_stage.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_execute_stage.sv

//--- testbench/execute_stim.txt
# unit alu div br wb memop size sgn op_a op_b store rd pc_next flags{lt,ltu,eq} stall exp_data exp_taken
# all hex; unit 0 none 1 alu 2 div 3 mem 4 branch; wb 1 result 2 pc_next
1 0 0 0 1 0 0 0 00000005 00000007 00000000 01 00000000 0 0 0000000c 0
1 1 0 0 1 0 0 0 00000005 00000007 00000000 02 00000000 0 0 fffffffe 0
1 7 0 0 1 0 0 0 80000010 00000004 00000000 03 00000000 0 0 f8000001 0
1 6 0 0 1 0 0 0 80000010 00000004 00000000 04 00000000 0 0 08000001 0
1 8 0 0 1 0 0 0 ffffffff 00000001 00000000 05 00000000 0 0 00000001 0
1 9 0 0 1 0 0 0 ffffffff 00000001 00000000 06 00000000 0 0 00000000 0
1 4 0 0 1 0 0 0 f0f0f0f0 ffff0000 00000000 07 00000000 0 0 0f0ff0f0 0
1 0 0 0 1 0 0 0 00000100 00000023 00000000 08 00000000 0 1 00000123 0
4 0 0 1 0 0 0 0 00001000 00000024 00000000 00 00000000 1 0 00000000 1
4 0 0 2 0 0 0 0 00001000 00000024 00000000 00 00000000 1 0 00000000 0
4 0 0 3 0 0 0 0 00001000 00000024 00000000 00 00000000 4 0 00000000 1
4 0 0 4 0 0 0 0 00001000 00000024 00000000 00 00000000 4 0 00000000 0
4 0 0 5 0 0 0 0 00001000 00000024 00000000 00 00000000 2 0 00000000 1
4 0 0 6 0 0 0 0 00001000 00000024 00000000 00 00000000 0 0 00000000 1
4 0 0 7 2 0 0 0 00001000 00000024 00000000 09 00000040 0 0 00000000 1
4 0 0 8 0 0 0 0 00002000 00000006 00000000 00 00000000 0 0 00000000 1
2 0 0 0 1 0 0 0 00000007 fffffffe 00000000 0a 00000000 0 0 fffffffd 0
2 0 2 0 1 0 0 0 00000007 fffffffe 00000000 0b 00000000 0 0 00000001 0
2 0 1 0 1 0 0 0 00000064 00000007 00000000 0c 00000000 0 0 0000000e 0
2 0 3 0 1 0 0 0 00000064 00000007 00000000 0d 00000000 0 0 00000002 0
2 0 0 0 1 0 0 0 00000005 00000000 00000000 0e 00000000 0 0 ffffffff 0
2 0 2 0 1 0 0 0 00000005 00000000 00000000 0f 00000000 0 0 00000005 0
2 0 0 0 1 0 0 0 80000000 ffffffff 00000000 10 00000000 0 0 80000000 0
2 0 2 0 1 0 0 0 80000000 ffffffff 00000000 11 00000000 0 0 00000000 0
3 0 0 0 0 1 0 0 00000010 00000005 000000f0 00 00000000 0 0 00000000 0
3 0 0 0 1 0 0 1 00000010 00000005 00000000 12 00000000 0 0 fffffff0 0
3 0 0 0 1 0 0 0 00000010 00000005 00000000 13 00000000 0 0 000000f0 0
3 0 0 0 1 0 1 1 00000010 00000004 00000000 14 00000000 0 0 fffff0a0 0
3 0 0 0 1 0 1 0 00000010 00000006 00000000 15 00000000 0 0 0000a0a0 0
3 0 0 0 1 0 2 0 00000010 00000004 00000000 16 00000000 0 0 a0a0f0a0 0
3 0 0 0 1 0 2 0 00000010 00000000 00000000 17 00000000 0 0 a1a1a1a1 0
3 0 0 0 0 1 1 0 00000010 0000000a 00008001 00 00000000 0 0 00000000 0
3 0 0 0 1 0 1 1 00000010 0000000a 00000000 18 00000000 0 0 ffff8001 0

//--- testbench/tb_checker.sv
// Execute stage result checker
`timescale 1ns/100ps
`default_nettype none

module tb_checker import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              ready_o,
    input  wire              stall_i,
    input  wire unit_e       unit_i,
    input  wire wb_sel_e     wb_sel_i,
    input  wire [XLEN-1:0]   op_a_i,
    input  wire [XLEN-1:0]   op_b_i,
    input  wire [4:0]        rd_addr_i,
    input  wire [31:1]       pc_next_i,
    input  wire              branch_taken_o,
    input  wire [31:1]       branch_target_o,
    input  wire [4:0]        wb_rd_addr_o,
    input  wire [XLEN-1:0]   wb_rd_data_o,
    input  wire [31:1]       wb_pc_next_o,
    input  wire wb_sel_e     wb_sel_o,
    input  wire [XLEN-1:0]   fwd_data_o,
    input  wire              mem_req_o,
    input  wire              mem_ack_i,
    input  wire [31:0]       test_num_i,
    input  wire [XLEN-1:0]   exp_data_i,
    input  wire              exp_taken_i,
    output int               err_count_o,
    output int               test_count_o
);

    // Operation as seen on the last falling edge
    unit_e           unit_q;
    wb_sel_e         sel_q;
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;
    logic [4:0]      rd_q;
    logic [31:1]     pc_q;
    logic            taken_q;
    logic [31:1]     target_q;
    logic [XLEN-1:0] fwd_q;
    logic            hold_q;
    logic [XLEN-1:0] hold_data_q;
    logic            req_q;
    logic [31:0]     seen_num = '0;
    int              low_cycles = 0;

    initial begin
        err_count_o  = 0;
        test_count_o = 0;
    end

    task automatic report(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        err_count_o++;
    endtask

    task automatic check_test();
        int          errs_before;
        wb_sel_e     exp_sel;
        logic [31:0] exp_sum;
        errs_before = err_count_o;
        exp_sel     = (unit_q == UNIT_NONE) ? WB_NONE : sel_q;
        exp_sum     = a_q + b_q;
        test_count_o++;
        if (wb_sel_o !== exp_sel)
            report($sformatf("wb_sel %0d, expected %0d", wb_sel_o, exp_sel));
        if (wb_rd_addr_o !== rd_q)
            report($sformatf("wb_rd_addr %0d, expected %0d", wb_rd_addr_o, rd_q));
        if (exp_sel == WB_RESULT && wb_rd_data_o !== exp_data_i)
            report($sformatf("wb_rd_data %h, expected %h", wb_rd_data_o, exp_data_i));
        if (exp_sel == WB_RESULT && fwd_q !== exp_data_i)
            report($sformatf("fwd_data %h, expected %h", fwd_q, exp_data_i));
        if (exp_sel == WB_PC_NEXT && wb_pc_next_o !== pc_q)
            report($sformatf("wb_pc_next %h, expected %h", wb_pc_next_o, pc_q));
        if (taken_q !== exp_taken_i)
            report($sformatf("branch_taken %b, expected %b", taken_q, exp_taken_i));
        if (unit_q == UNIT_BRANCH && target_q !== exp_sum[31:1])   // Target is (a+b)>>1
            report($sformatf("branch_target %h, expected %h", target_q, exp_sum[31:1]));
        if (unit_q == UNIT_DIV && low_cycles != XLEN + 1)
            report($sformatf("divider busy %0d cycles, expected %0d", low_cycles, XLEN + 1));
        $display("test %0d %s", test_num_i, (err_count_o == errs_before) ? "ok" : "FAILED");
    endtask

    always @(negedge clk_i) begin
        if (rst_i) begin
            hold_q = 1'b0;
            req_q  = 1'b0;
        end else begin
            if (test_num_i != seen_num) begin
                seen_num = test_num_i;
                check_test();
                low_cycles = 0;
            end
            if (!ready_o) low_cycles++;

            if (hold_q && wb_rd_data_o !== hold_data_q)
                report($sformatf("wb_rd_data changed to %h under stall", wb_rd_data_o));

            // Four-phase order on the memory port
            if (ready_o && mem_ack_i)
                report("ready_o high while mem_ack_i still high");
            if (!mem_req_o && req_q && !mem_ack_i)
                report("mem_req_o dropped before mem_ack_i");

            hold_q      = stall_i && ready_o;
            hold_data_q = wb_rd_data_o;
            req_q       = mem_req_o;
            unit_q      = unit_i;
            sel_q       = wb_sel_i;
            a_q         = op_a_i;
            b_q         = op_b_i;
            rd_q        = rd_addr_i;
            pc_q        = pc_next_i;
            taken_q     = branch_taken_o;
            target_q    = branch_target_o;
            fwd_q       = fwd_data_o;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// Testbench clock source
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD = 10.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2.0) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- testbench/tb_execute_stage.sv
// Execute stage testbench
`timescale 1ns/100ps
`default_nettype none

module tb_execute_stage import exec_pkg::*, mem_pkg::*;;

    localparam int XLEN = 32;
    localparam int CYCLES_PER_LINE = 200;
    localparam string STIM_FILE = "testbench/execute_stim.txt";

    logic            clk_i;
    logic            rst_i;
    logic            stall_i;
    logic            ready_o;
    unit_e           unit_i;
    alu_op_e         alu_op_i;
    div_op_e         div_op_i;
    branch_op_e      branch_op_i;
    wb_sel_e         wb_sel_i;
    mem_op_e         mem_op_i;
    mem_size_e       mem_size_i;
    logic            mem_signed_i;
    logic [XLEN-1:0] op_a_i;
    logic [XLEN-1:0] op_b_i;
    logic [31:0]     store_data_i;
    logic [4:0]      rd_addr_i;
    logic [31:1]     pc_next_i;
    logic [2:0]      cmp_flags_i;
    logic            branch_taken_o;
    logic [31:1]     branch_target_o;
    logic [4:0]      wb_rd_addr_o;
    logic [XLEN-1:0] wb_rd_data_o;
    logic [31:1]     wb_pc_next_o;
    wb_sel_e         wb_sel_o;
    logic [XLEN-1:0] fwd_data_o;
    logic            mem_req_o;
    logic [31:0]     mem_addr_o;
    logic [31:0]     mem_wdata_o;
    logic [3:0]      mem_mask_o;
    logic            mem_we_o;
    logic            mem_ack_i;
    logic [31:0]     mem_rdata_i;

    logic [31:0]     mem [64];
    logic [31:0]     test_num;
    logic [XLEN-1:0] exp_data;
    logic            exp_taken;
    int              line_total = 0;
    int              err_count;
    int              test_count;
    int              delay;

    tb_clock #(.PERIOD(10.0)) clock_i (.clk_o(clk_i));

    execute_stage #(.XLEN(XLEN)) dut_i (.*);

    tb_checker #(.XLEN(XLEN)) checker_i (
        .test_num_i  (test_num),
        .exp_data_i  (exp_data),
        .exp_taken_i (exp_taken),
        .err_count_o (err_count),
        .test_count_o(test_count),
        .*
    );

    // Memory model, acks after a random delay of 1 to 4 cycles
    always begin
        @(negedge clk_i);
        if (mem_req_o && !mem_ack_i) begin
            delay = 1 + ($urandom % 4);
            repeat (delay) @(posedge clk_i);
            #1;
            for (int i = 0; i < 4; i++) begin
                if (mem_we_o && mem_mask_o[i])
                    mem[mem_addr_o[7:2]][8*i +: 8] = mem_wdata_o[8*i +: 8];
            end
            mem_rdata_i = mem[mem_addr_o[7:2]];
            mem_ack_i   = 1'b1;
            do @(negedge clk_i); while (mem_req_o);
            @(posedge clk_i);
            #1 mem_ack_i = 1'b0;
        end
    end

    // Watchdog sized from the number of stimulus lines
    initial begin
        wait (line_total > 0);
        repeat (line_total * CYCLES_PER_LINE) @(posedge clk_i);
        $display("Run timed out after %0d cycles", line_total * CYCLES_PER_LINE);
        $display("Simulation failed");
        $finish;
    end

    function automatic bit is_data_line(input string line);
        return line.len() > 1 && line[0] != "#";
    endfunction

    task automatic run_line(input logic [31:0] f[17]);
        @(posedge clk_i);
        #1;
        unit_i       = unit_e'(f[0][2:0]);
        alu_op_i     = alu_op_e'(f[1][3:0]);
        div_op_i     = div_op_e'(f[2][1:0]);
        branch_op_i  = branch_op_e'(f[3][3:0]);
        wb_sel_i     = wb_sel_e'(f[4][1:0]);
        mem_op_i     = mem_op_e'(f[5][0]);
        mem_size_i   = mem_size_e'(f[6][1:0]);
        mem_signed_i = f[7][0];
        op_a_i       = f[8];
        op_b_i       = f[9];
        store_data_i = f[10];
        rd_addr_i    = f[11][4:0];
        pc_next_i    = f[12][30:0];
        cmp_flags_i  = f[13][2:0];
        stall_i      = f[14][0];
        exp_data     = f[15];
        exp_taken    = f[16][0];
        if (stall_i) begin
            repeat (3) @(negedge clk_i);   // Write-back must hold here
            @(posedge clk_i);
            #1 stall_i = 1'b0;
        end
        do @(negedge clk_i); while (!(ready_o && !stall_i));
        @(posedge clk_i);
        #1;
        test_num = test_num + 1;
        unit_i   = UNIT_NONE;                // Bubble lets the units return to idle
        wb_sel_i = WB_NONE;
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f[17];
        void'($urandom(32'h836d));
        rst_i = 1'b1;
        stall_i = 1'b0;
        unit_i = UNIT_NONE;
        alu_op_i = ADD;
        div_op_i = DIV;
        branch_op_i = BR_NONE;
        wb_sel_i = WB_NONE;
        mem_op_i = MEM_LOAD;
        mem_size_i = SIZE_W;
        mem_signed_i = 1'b0;
        op_a_i = '0;
        op_b_i = '0;
        store_data_i = '0;
        rd_addr_i = '0;
        pc_next_i = '0;
        cmp_flags_i = '0;
        mem_ack_i = 1'b0;
        mem_rdata_i = '0;
        test_num = '0;
        exp_data = '0;
        exp_taken = 1'b0;
        for (int i = 0; i < 64; i++) mem[i] = i * 32'h01010101 ^ 32'hA5A5A5A5;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            $display("Simulation failed");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) if (is_data_line(line)) line_total++;
            $fclose(fd);
            fd = $fopen(STIM_FILE, "r");
            repeat (16) @(posedge clk_i);
            #1 rst_i = 1'b0;
            while ($fgets(line, fd) > 0) begin
                if (is_data_line(line)) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                    if (n == 17) run_line(f);
                    else $display("Malformed stimulus line skipped: %s", line);
                end
            end
            $fclose(fd);
            repeat (2) @(posedge clk_i);
            $display("%0d tests run, %0d errors", test_count, err_count);
            if (err_count == 0 && line_total > 0 && test_count == line_total) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
